/* common/bert_settings.svh */
`ifndef BERT_SETTINGS_SVH
`define BERT_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// bus and datapath widths

// apb data bus, also the serdes parallel word
`define BERT_DATA_WIDTH 16

// apb byte address, registers sit on 4 byte steps
`define BERT_ADDR_WIDTH 8

////////////////////////////////////////////////////////////////////////////
// checker

// bit error counter, saturates instead of wrapping
`define BERT_ERRCNT_WIDTH 16

`endif

/* common/bert_pkg.sv */
`default_nettype none

package bert_pkg;

	`include "bert_settings.svh"

	////////////////////////////////////////////////////////////////////////////
	// basic widths

	typedef logic [`BERT_DATA_WIDTH-1:0]	data_word_t;
	typedef logic [`BERT_ADDR_WIDTH-1:0]	apb_addr_t;
	typedef logic [`BERT_ERRCNT_WIDTH-1:0]	err_count_t;

	// sequence history, bit 0 oldest; 32 bits covers the prbs31 taps
	typedef logic [31:0]					prbs_hist_t;

	// 6 and 7 are reserved and behave as off
	typedef enum logic [2:0] {
		PRBS_OFF	= 3'd0,
		PRBS_7		= 3'd1,
		PRBS_9		= 3'd2,
		PRBS_15		= 3'd3,
		PRBS_23		= 3'd4,
		PRBS_31		= 3'd5
	} prbs_mode_t;

	////////////////////////////////////////////////////////////////////////////
	// apb request and response

	typedef struct packed {
		logic		psel;
		logic		penable;
		logic		pwrite;
		apb_addr_t	paddr;
		data_word_t	pwdata;
	} apb_req_t;

	typedef struct packed {
		data_word_t	prdata;
		logic		pready;
		logic		pslverr;
	} apb_rsp_t;

	////////////////////////////////////////////////////////////////////////////
	// serdes pin configuration

	typedef struct packed {
		logic		enable;
		logic		invert;
		prbs_mode_t	prbsmode;
		logic		clk_from_qpll;
		logic [2:0]	clkdiv;
		logic		tx_reset;
		logic [3:0]	swing;
		logic [4:0]	postcursor;
		logic [4:0]	precursor;
	} bert_txconfig_t;

	typedef struct packed {
		logic		invert;
		prbs_mode_t	prbsmode;
		logic		clk_from_qpll;
		logic [2:0]	clkdiv;
		logic		rx_reset;
		logic		pmareset;
	} bert_rxconfig_t;

	////////////////////////////////////////////////////////////////////////////
	// next 16 sequence bits from the last 32, oldest first
	// bit 0 of the result only looks at hist, never at other result bits

	function automatic data_word_t prbs_next_word(
		input prbs_mode_t	mode,
		input prbs_hist_t	hist
	);
		logic [$bits(prbs_hist_t)+`BERT_DATA_WIDTH-1:0]	seq;
		int unsigned									tap_a;
		int unsigned									tap_b;
		seq = {{`BERT_DATA_WIDTH{1'b0}}, hist};
		// s[n] = s[n-a] ^ s[n-b]
		case (mode)
			PRBS_7: begin
				tap_a = 7;
				tap_b = 6;
			end
			PRBS_9: begin
				tap_a = 9;
				tap_b = 5;
			end
			PRBS_15: begin
				tap_a = 15;
				tap_b = 14;
			end
			PRBS_23: begin
				tap_a = 23;
				tap_b = 18;
			end
			PRBS_31: begin
				tap_a = 31;
				tap_b = 28;
			end
			// same tap twice, every bit cancels to zero
			default: begin
				tap_a = 1;
				tap_b = 1;
			end
		endcase
		for (int i = 0; i < `BERT_DATA_WIDTH; i++) begin
			seq[32 + i] = seq[32 + i - tap_a] ^ seq[32 + i - tap_b];
		end
		return seq[$bits(seq)-1:$bits(prbs_hist_t)];
	endfunction

endpackage

`default_nettype wire

/* design/bert_config_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module bert_config_regs(
	input wire							apb,
	input wire							arst_n,

	// apb completer, zero wait states
	input wire bert_pkg::apb_req_t		apb_req,
	output bert_pkg::apb_rsp_t			apb_rsp,

	// live count from the checker
	input wire bert_pkg::err_count_t	err_count,

	// pin configuration out to the lane
	output bert_pkg::bert_txconfig_t	tx_config,
	output bert_pkg::bert_rxconfig_t	rx_config,
	output logic						config_updated
);

	import bert_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// register map
	// reset bits are plain levels, software sets and clears them

	// 15 enable, 14 invert, 2:0 prbs mode
	localparam apb_addr_t REG_TX_CONFIG		= 8'h00;
	// 15 qpll select, 2:0 clock divide
	localparam apb_addr_t REG_TX_CLK		= 8'h04;
	// 0 full tx reset
	localparam apb_addr_t REG_TX_RESET		= 8'h08;
	// 3:0 swing, 8:4 postcursor, 13:9 precursor
	localparam apb_addr_t REG_TX_DRIVER		= 8'h0c;
	// 14 invert, 2:0 prbs mode
	localparam apb_addr_t REG_RX_CONFIG		= 8'h40;
	// 15 qpll select, 2:0 clock divide
	localparam apb_addr_t REG_RX_CLK		= 8'h44;
	// 0 full rx reset, 1 pma reset
	localparam apb_addr_t REG_RX_RESET		= 8'h48;
	// checker error count, read only
	localparam apb_addr_t REG_RX_ERRCOUNT	= 8'h4c;

	////////////////////////////////////////////////////////////////////////////
	// address decode and readback

	logic		access;
	logic		reg_hit;
	logic		reg_ro;
	logic		wr_en;
	data_word_t	rd_data;

	always_comb begin
		// access phase of the two phase transfer
		access	= apb_req.psel && apb_req.penable;
		reg_hit	= 1'b1;
		reg_ro	= 1'b0;
		rd_data	= '0;

		case (apb_req.paddr)
			REG_TX_CONFIG:
				rd_data = {tx_config.enable, tx_config.invert, 11'h0, tx_config.prbsmode};
			REG_TX_CLK:
				rd_data = {tx_config.clk_from_qpll, 12'h0, tx_config.clkdiv};
			REG_TX_RESET:
				rd_data = {15'h0, tx_config.tx_reset};
			REG_TX_DRIVER:
				rd_data = {2'h0, tx_config.precursor, tx_config.postcursor, tx_config.swing};
			REG_RX_CONFIG:
				rd_data = {1'b0, rx_config.invert, 11'h0, rx_config.prbsmode};
			REG_RX_CLK:
				rd_data = {rx_config.clk_from_qpll, 12'h0, rx_config.clkdiv};
			REG_RX_RESET:
				rd_data = {14'h0, rx_config.pmareset, rx_config.rx_reset};
			REG_RX_ERRCOUNT: begin
				rd_data	= data_word_t'(err_count);
				reg_ro	= 1'b1;
			end
			// unmapped, reads back zero
			default:
				reg_hit = 1'b0;
		endcase

		// only mapped writable registers take a write
		wr_en = access && apb_req.pwrite && reg_hit && !reg_ro;

		// response, always ready in the access phase
		apb_rsp.pready	= access;
		apb_rsp.pslverr	= access && (!reg_hit || (apb_req.pwrite && reg_ro));
		apb_rsp.prdata	= (access && !apb_req.pwrite) ? rd_data : '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// configuration storage

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			tx_config		<= '0;
			rx_config		<= '0;
			config_updated	<= 1'b0;
		end
		else begin
			// pulses for rejected writes too
			config_updated	<= access && apb_req.pwrite;

			if (wr_en) begin
				case (apb_req.paddr)
					REG_TX_CONFIG: begin
						tx_config.prbsmode		<= prbs_mode_t'(apb_req.pwdata[2:0]);
						tx_config.invert		<= apb_req.pwdata[14];
						tx_config.enable		<= apb_req.pwdata[15];
					end
					REG_TX_CLK: begin
						tx_config.clkdiv		<= apb_req.pwdata[2:0];
						tx_config.clk_from_qpll	<= apb_req.pwdata[15];
					end
					REG_TX_RESET: begin
						tx_config.tx_reset		<= apb_req.pwdata[0];
					end
					REG_TX_DRIVER: begin
						tx_config.swing			<= apb_req.pwdata[3:0];
						tx_config.postcursor	<= apb_req.pwdata[8:4];
						tx_config.precursor		<= apb_req.pwdata[13:9];
					end
					REG_RX_CONFIG: begin
						rx_config.prbsmode		<= prbs_mode_t'(apb_req.pwdata[2:0]);
						rx_config.invert		<= apb_req.pwdata[14];
					end
					REG_RX_CLK: begin
						rx_config.clkdiv		<= apb_req.pwdata[2:0];
						rx_config.clk_from_qpll	<= apb_req.pwdata[15];
					end
					REG_RX_RESET: begin
						rx_config.rx_reset		<= apb_req.pwdata[0];
						rx_config.pmareset		<= apb_req.pwdata[1];
					end
					// wr_en already filters everything else
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* prbs_gen/prbs_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bert_settings.svh"

module prbs_gen(
	input wire							apb,
	input wire							arst_n,

	// enable, invert, mode and reset are used here
	input wire bert_pkg::bert_txconfig_t	tx_config,

	// one word per clock toward the serdes
	output bert_pkg::data_word_t		tx_data
);

	import bert_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// run control

	// last 32 sequence bits, bit 0 oldest
	prbs_hist_t	hist;
	data_word_t	next_word;
	logic		mode_valid;
	logic		running;

	always_comb begin
		// reserved modes count as off
		mode_valid	= (tx_config.prbsmode != PRBS_OFF) && (tx_config.prbsmode <= PRBS_31);
		running		= tx_config.enable && !tx_config.tx_reset && mode_valid;

		// next word straight from the history
		next_word	= prbs_next_word(tx_config.prbsmode, hist);
	end

	////////////////////////////////////////////////////////////////////////////
	// sequence state and output word

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			// all ones seed is nonzero for every mode
			hist	<= '1;
			tx_data	<= '0;
		end
		else if (running) begin
			// newest word shifts in at the top
			hist	<= {next_word, hist[$bits(prbs_hist_t)-1:`BERT_DATA_WIDTH]};

			// optional polarity flip on the line only
			if (tx_config.invert)
				tx_data	<= ~next_word;
			else
				tx_data	<= next_word;
		end
		else begin
			// idle, reseed so the next run starts clean
			hist	<= '1;
			tx_data	<= '0;
		end
	end

endmodule

`default_nettype wire

/* prbs_check/prbs_check.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bert_settings.svh"

module prbs_check(
	input wire							apb,
	input wire							arst_n,

	// invert, mode and rx_reset are used here
	input wire bert_pkg::bert_rxconfig_t	rx_config,

	// parallel word from the serdes
	input wire bert_pkg::data_word_t	rx_data,

	// saturating bit error count
	output bert_pkg::err_count_t		err_count
);

	import bert_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// stage 1: capture, undo inversion

	data_word_t	rx_word;
	// 32 received bits before rx_word, bit 0 oldest
	prbs_hist_t	hist;

	////////////////////////////////////////////////////////////////////////////
	// per bit prediction from received bits only
	// a single flipped bit hits its own slot and both tap slots

	logic [$bits(prbs_hist_t)+`BERT_DATA_WIDTH-1:0]	window;
	data_word_t									pred_word;
	data_word_t									pred;
	data_word_t									mismatch;
	logic [$clog2(`BERT_DATA_WIDTH):0]			ones;
	logic [$clog2(`BERT_DATA_WIDTH):0]			err_bits;
	logic [`BERT_ERRCNT_WIDTH:0]				sum;
	logic										counting;

	always_comb begin
		window = {rx_word, hist};

		// bit i sees the 32 received bits just before it
		for (int i = 0; i < `BERT_DATA_WIDTH; i++) begin
			pred_word	= prbs_next_word(rx_config.prbsmode, window[i +: $bits(prbs_hist_t)]);
			pred[i]		= pred_word[0];
		end
		mismatch = rx_word ^ pred;

		// popcount of the mismatch word
		ones = '0;
		for (int i = 0; i < `BERT_DATA_WIDTH; i++) begin
			ones = ones + {{($bits(ones)-1){1'b0}}, mismatch[i]};
		end

		// nothing counted while held in reset or with no valid mode
		counting = !rx_config.rx_reset &&
			(rx_config.prbsmode != PRBS_OFF) && (rx_config.prbsmode <= PRBS_31);

		// widened add, top bit flags overflow
		sum = {1'b0, err_count} + (`BERT_ERRCNT_WIDTH+1)'(err_bits);
	end

	////////////////////////////////////////////////////////////////////////////
	// pipeline: capture, count, accumulate

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			rx_word		<= '0;
			hist		<= '0;
			err_bits	<= '0;
			err_count	<= '0;
		end
		else begin
			if (rx_config.invert)
				rx_word	<= ~rx_data;
			else
				rx_word	<= rx_data;
			hist		<= {rx_word, hist[$bits(prbs_hist_t)-1:`BERT_DATA_WIDTH]};

			// stage 2
			err_bits	<= counting ? ones : '0;

			// stage 3, held at zero in rx reset, sticks at all ones
			if (rx_config.rx_reset)
				err_count	<= '0;
			else if (sum[`BERT_ERRCNT_WIDTH])
				err_count	<= '1;
			else
				err_count	<= sum[`BERT_ERRCNT_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

/* design/bert_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module bert_lane(
	input wire							apb,
	input wire							arst_n,

	// register access
	input wire bert_pkg::apb_req_t		apb_req,
	output wire bert_pkg::apb_rsp_t		apb_rsp,

	// parallel data to and from the serdes
	output wire bert_pkg::data_word_t	tx_data,
	input wire bert_pkg::data_word_t	rx_data,

	// pin configuration for the serdes primitive
	output wire bert_pkg::bert_txconfig_t	tx_config,
	output wire bert_pkg::bert_rxconfig_t	rx_config,
	output wire							config_updated
);

	import bert_pkg::*;

	// checker count back into the register block
	wire err_count_t	err_count;

	////////////////////////////////////////////////////////////////////////////
	// apb registers

	bert_config_regs u_bert_config_regs(
		.apb			(apb),
		.arst_n			(arst_n),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp),
		.err_count		(err_count),
		.tx_config		(tx_config),
		.rx_config		(rx_config),
		.config_updated	(config_updated)
	);

	////////////////////////////////////////////////////////////////////////////
	// transmit side

	prbs_gen u_prbs_gen(
		.apb		(apb),
		.arst_n		(arst_n),
		.tx_config	(tx_config),
		.tx_data	(tx_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// receive side

	prbs_check u_prbs_check(
		.apb		(apb),
		.arst_n		(arst_n),
		.rx_config	(rx_config),
		.rx_data	(rx_data),
		.err_count	(err_count)
	);

endmodule

`default_nettype wire

/* tests/bert_lane_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module bert_lane_tb;

	import bert_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// timing and test constants

	localparam int CLK_PERIOD		= 100;
	localparam int DRIVE_DELAY		= 10;
	// mid cycle, combinational apb response is settled
	localparam int SAMPLE_DELAY		= 40;
	// error mask lands before the loopback copy at DRIVE_DELAY
	localparam int INJECT_DELAY		= 2;
	localparam int SEED				= 5116;
	localparam int LOOP_WORDS		= 200;
	// tests take about 1800 cycles, mostly the six loopback runs
	localparam int WATCHDOG_CYCLES	= 4000;

	localparam apb_addr_t TX_CONFIG_ADDR	= 8'h00;
	localparam apb_addr_t TX_RESET_ADDR		= 8'h08;
	localparam apb_addr_t RX_CONFIG_ADDR	= 8'h40;
	localparam apb_addr_t RX_RESET_ADDR		= 8'h48;
	localparam apb_addr_t ERRCOUNT_ADDR		= 8'h4c;

	// writable registers and their defined bits
	localparam apb_addr_t REG_ADDR [7] = '{8'h00, 8'h04, 8'h08, 8'h0c, 8'h40, 8'h44, 8'h48};
	localparam data_word_t REG_MASK [7] = '{16'hc007, 16'h8007, 16'h0001, 16'h3fff,
		16'h4007, 16'h8007, 16'h0003};

	logic			apb;
	logic			arst_n;
	apb_req_t		apb_req;
	apb_rsp_t		apb_rsp;
	data_word_t		tx_data;
	data_word_t		rx_data;
	bert_txconfig_t	tx_config;
	bert_rxconfig_t	rx_config;
	logic			config_updated;
	// bits flipped on the loopback path
	data_word_t		err_mask;
	int				mismatches;
	int				failures;

	bert_lane u_bert_lane(
		.apb			(apb),
		.arst_n			(arst_n),
		.apb_req		(apb_req),
		.apb_rsp		(apb_rsp),
		.tx_data		(tx_data),
		.rx_data		(rx_data),
		.tx_config		(tx_config),
		.rx_config		(rx_config),
		.config_updated	(config_updated)
	);

	initial begin
		apb = 1'b0;
		forever #(CLK_PERIOD / 2) apb = ~apb;
	end

	// serial loopback, tx word back to rx with optional bit flips
	initial begin
		rx_data = '0;
		forever begin
			@(posedge apb);
			#DRIVE_DELAY;
			rx_data = tx_data ^ err_mask;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge apb);
		$display("ERROR: watchdog expired after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// reporting and apb access

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		mismatches++;
		$display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got,
			expected);
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	// setup phase, access phase, then back to idle
	task automatic apb_transfer(input logic write, input apb_addr_t addr,
		input data_word_t wdata, output data_word_t rdata, output logic slverr);
		@(posedge apb);
		#DRIVE_DELAY;
		apb_req.psel	= 1'b1;
		apb_req.penable	= 1'b0;
		apb_req.pwrite	= write;
		apb_req.paddr	= addr;
		apb_req.pwdata	= wdata;
		@(posedge apb);
		#DRIVE_DELAY;
		apb_req.penable	= 1'b1;
		#SAMPLE_DELAY;
		rdata	= apb_rsp.prdata;
		slverr	= apb_rsp.pslverr;
		if (apb_rsp.pready !== 1'b1)
			report_failure($sformatf("pready low in access phase to 0x%02h", addr));
		if (config_updated !== 1'b0)
			report_mismatch("config_updated during access", 32'(config_updated), 32'd0);
		@(posedge apb);
		#DRIVE_DELAY;
		apb_req = '0;
		// one cycle pulse only after a write
		if (config_updated !== write)
			report_mismatch("config_updated after access", 32'(config_updated), 32'(write));
	endtask

	task automatic apb_write(input apb_addr_t addr, input data_word_t data,
		output logic slverr);
		data_word_t rdata;
		apb_transfer(1'b1, addr, data, rdata, slverr);
	endtask

	task automatic apb_read(input apb_addr_t addr, output data_word_t rdata,
		output logic slverr);
		apb_transfer(1'b0, addr, '0, rdata, slverr);
	endtask

	task automatic expect_write(input apb_addr_t addr, input data_word_t data,
		input logic exp_err);
		logic slverr;
		apb_write(addr, data, slverr);
		if (slverr !== exp_err)
			report_mismatch($sformatf("pslverr on write to 0x%02h", addr), 32'(slverr),
				32'(exp_err));
	endtask

	task automatic expect_read(input apb_addr_t addr, input data_word_t exp_data,
		input logic exp_err);
		data_word_t	rdata;
		logic		slverr;
		apb_read(addr, rdata, slverr);
		if (rdata !== exp_data)
			report_mismatch($sformatf("read data at 0x%02h", addr), 32'(rdata), 32'(exp_data));
		if (slverr !== exp_err)
			report_mismatch($sformatf("pslverr on read of 0x%02h", addr), 32'(slverr),
				32'(exp_err));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// loopback helpers

	// flip one bit for one word, next flip no earlier than 4 words on
	task automatic inject_bit(input int pos);
		@(posedge apb);
		#INJECT_DELAY;
		err_mask = data_word_t'(1) << pos;
		@(posedge apb);
		#INJECT_DELAY;
		err_mask = '0;
		repeat (2) @(posedge apb);
	endtask

	// checker held in reset until its history is filled with real words
	task automatic start_loopback(input logic [2:0] mode, input logic inv);
		expect_write(RX_RESET_ADDR, 16'h0001, 1'b0);
		// disabled generator reseeds to all ones
		expect_write(TX_CONFIG_ADDR, 16'h0000, 1'b0);
		expect_write(TX_RESET_ADDR, 16'h0000, 1'b0);
		expect_write(RX_CONFIG_ADDR, {1'b0, inv, 11'h0, mode}, 1'b0);
		expect_write(TX_CONFIG_ADDR, {1'b1, inv, 11'h0, mode}, 1'b0);
		repeat (4) @(posedge apb);
		expect_write(RX_RESET_ADDR, 16'h0000, 1'b0);
	endtask

	// tx config takes effect one edge after the write
	task automatic check_tx_idle(input int cycles);
		@(posedge apb);
		for (int i = 0; i < cycles; i++) begin
			@(posedge apb);
			#DRIVE_DELAY;
			if (tx_data !== '0)
				report_mismatch("tx_data while idle", 32'(tx_data), 32'd0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests

	task automatic check_reset_state();
		if (tx_config !== '0)
			report_mismatch("tx_config after reset", 32'(tx_config), 32'd0);
		if (rx_config !== '0)
			report_mismatch("rx_config after reset", 32'(rx_config), 32'd0);
		if (tx_data !== '0)
			report_mismatch("tx_data after reset", 32'(tx_data), 32'd0);
		if (config_updated !== 1'b0)
			report_mismatch("config_updated after reset", 32'(config_updated), 32'd0);
		for (int i = 0; i < 7; i++)
			expect_read(REG_ADDR[i], 16'h0000, 1'b0);
		expect_read(ERRCOUNT_ADDR, 16'h0000, 1'b0);
	endtask

	task automatic check_register_round_trip();
		data_word_t		val [7];
		bert_txconfig_t	exp_tx;
		bert_rxconfig_t	exp_rx;
		for (int i = 0; i < 7; i++) begin
			val[i] = data_word_t'($urandom());
			expect_write(REG_ADDR[i], val[i], 1'b0);
		end
		for (int i = 0; i < 7; i++)
			expect_read(REG_ADDR[i], val[i] & REG_MASK[i], 1'b0);

		// field positions per the register map
		exp_tx.enable			= val[0][15];
		exp_tx.invert			= val[0][14];
		exp_tx.prbsmode			= prbs_mode_t'(val[0][2:0]);
		exp_tx.clk_from_qpll	= val[1][15];
		exp_tx.clkdiv			= val[1][2:0];
		exp_tx.tx_reset			= val[2][0];
		exp_tx.swing			= val[3][3:0];
		exp_tx.postcursor		= val[3][8:4];
		exp_tx.precursor		= val[3][13:9];
		exp_rx.invert			= val[4][14];
		exp_rx.prbsmode			= prbs_mode_t'(val[4][2:0]);
		exp_rx.clk_from_qpll	= val[5][15];
		exp_rx.clkdiv			= val[5][2:0];
		exp_rx.rx_reset			= val[6][0];
		exp_rx.pmareset			= val[6][1];
		if (tx_config !== exp_tx)
			report_mismatch("tx_config fields", 32'(tx_config), 32'(exp_tx));
		if (rx_config !== exp_rx)
			report_mismatch("rx_config fields", 32'(rx_config), 32'(exp_rx));
	endtask

	task automatic check_illegal_access();
		bert_txconfig_t	tx_before;
		bert_rxconfig_t	rx_before;
		data_word_t		junk;
		tx_before	= tx_config;
		rx_before	= rx_config;
		junk		= data_word_t'($urandom());
		expect_read(8'h10, 16'h0000, 1'b1);
		expect_write(8'h10, junk, 1'b1);
		expect_read(8'h80, 16'h0000, 1'b1);
		expect_write(8'h80, junk, 1'b1);
		// count register is read only
		expect_write(ERRCOUNT_ADDR, junk, 1'b1);
		if (tx_config !== tx_before)
			report_mismatch("tx_config after illegal writes", 32'(tx_config), 32'(tx_before));
		if (rx_config !== rx_before)
			report_mismatch("rx_config after illegal writes", 32'(rx_config), 32'(rx_before));
	endtask

	task automatic run_loopback(input logic [2:0] mode, input logic inv);
		start_loopback(mode, inv);
		repeat (LOOP_WORDS) @(posedge apb);
		expect_read(ERRCOUNT_ADDR, 16'h0000, 1'b0);
	endtask

	// each lone flip shows in its own slot and both tap slots
	task automatic check_error_injection();
		int k;
		k = $urandom_range(1, 8);
		start_loopback(PRBS_7, 1'b0);
		for (int i = 0; i < k; i++)
			inject_bit($urandom_range(0, 15));
		repeat (8) @(posedge apb);
		expect_read(ERRCOUNT_ADDR, data_word_t'(3 * k), 1'b0);
		expect_write(RX_RESET_ADDR, 16'h0001, 1'b0);
		expect_read(ERRCOUNT_ADDR, 16'h0000, 1'b0);
	endtask

	task automatic check_disable();
		// prbs7 loopback still locked, count one flip to have a value to hold
		expect_write(RX_RESET_ADDR, 16'h0000, 1'b0);
		repeat (4) @(posedge apb);
		inject_bit($urandom_range(0, 15));
		repeat (8) @(posedge apb);
		expect_read(ERRCOUNT_ADDR, 16'd3, 1'b0);

		// reserved rx mode stops counting
		expect_write(RX_CONFIG_ADDR, 16'h0006, 1'b0);
		expect_write(TX_CONFIG_ADDR, 16'h0001, 1'b0);
		check_tx_idle(20);
		expect_read(ERRCOUNT_ADDR, 16'd3, 1'b0);

		// enabled but reserved tx mode, invert set so a running generator shows
		expect_write(TX_CONFIG_ADDR, {1'b1, 1'b1, 11'h0, 3'($urandom_range(6, 7))}, 1'b0);
		check_tx_idle(20);
		expect_read(ERRCOUNT_ADDR, 16'd3, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence

	initial begin
		void'($urandom(SEED));
		arst_n		= 1'b0;
		apb_req		= '0;
		err_mask	= '0;
		mismatches	= 0;
		failures	= 0;
		repeat (2) @(posedge apb);
		#DRIVE_DELAY;
		arst_n = 1'b1;

		check_reset_state();
		check_register_round_trip();
		check_illegal_access();
		run_loopback(PRBS_7, 1'b0);
		run_loopback(PRBS_15, 1'b0);
		run_loopback(PRBS_31, 1'b0);
		run_loopback(PRBS_7, 1'b1);
		run_loopback(PRBS_15, 1'b1);
		run_loopback(PRBS_31, 1'b1);
		check_error_injection();
		check_disable();

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("Done: no errors");
		end
		else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bert_lane.f */
+incdir+common
common/bert_pkg.sv
design/bert_config_regs.sv
prbs_gen/prbs_gen.sv
prbs_check/prbs_check.sv
design/bert_lane.sv
tests/bert_lane_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bert lane testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module bert_lane_tb \
	-f bert_lane.f \
	--Mdir build/obj_dir \
	-o bert_lane_sim

./build/obj_dir/bert_lane_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
